//--- design/rvfiPkg.sv
package rvfiPkg;

   //////////////////////////////
   // Retirement record widths
   //////////////////////////////

   // Machine word for PC, instruction, GPR and CSR data
   typedef logic [31:0] xlenWordT;

   // Retirement order number, unique per retired instruction
   typedef logic [63:0] orderT;

   // GPR index
   typedef logic [4:0] regAddrT;

   // Exception cause as reported in the trap field
   typedef logic [5:0] excCauseT;

   // Interrupt cause as reported in the intr field, wide enough for NMI codes
   typedef logic [10:0] intrCauseT;

   // Debug entry cause
   typedef logic [2:0] dbgCauseT;

   // Privilege mode
   typedef logic [1:0] privModeT;

   //////////////////////////////
   // Cause codes
   //////////////////////////////

   // Instruction fetch bus fault, raised outside the hart model
   localparam excCauseT FetchFaultCause = excCauseT'(48);

   // NMI for a load bus error
   localparam intrCauseT NmiLoadCause = intrCauseT'(1024);

   // NMI for a store bus error
   localparam intrCauseT NmiStoreCause = intrCauseT'(1025);

   // Debug entry by external halt request
   localparam dbgCauseT DbgHaltCause = dbgCauseT'(3);

endpackage

//--- design/rvviPkg.sv
package rvviPkg;

   //////////////////////////////
   // Net events
   //////////////////////////////

   // An event is a net id with the new level of that net
   typedef logic [4:0] netIdT;

   // Wide enough to carry an NMI cause
   typedef logic [10:0] netValueT;

   // Interrupt lines of the basic interrupt scheme
   localparam int NumIrqNets = 19;

   // irq_i bit for each interrupt net, in net id order
   // Software, timer, external, then local 0 to 15
   localparam int IrqLineTable [NumIrqNets] = '{
      3, 7, 11,
      16, 17, 18, 19, 20, 21, 22, 23,
      24, 25, 26, 27, 28, 29, 30, 31
   };

   // Nets after the interrupt lines
   localparam netIdT NetIfault   = netIdT'(19);
   localparam netIdT NetNmi      = netIdT'(20);
   localparam netIdT NetNmiCause = netIdT'(21);
   localparam netIdT NetHaltReq  = netIdT'(22);

   localparam int NumNets = 23;

   //////////////////////////////
   // Tracked CSRs
   //////////////////////////////

   localparam int NumCsr = 8;

   typedef logic [2:0] csrIdxT;

   // CSR address per shadow index
   localparam logic [11:0] CsrAddrTable [NumCsr] = '{
      12'h300,  // mstatus
      12'h304,  // mie
      12'h305,  // mtvec
      12'h340,  // mscratch
      12'h341,  // mepc
      12'h342,  // mcause
      12'h343,  // mtval
      12'h7B0   // dcsr
   };

endpackage

//--- design/retireStage.sv
`timescale 1ns/1ns

module retireStage
   import rvfiPkg::*;
(
   input  logic      rvvi,
   input  logic      reset_i,

   input  logic      retValid_i,
   input  orderT     retOrder_i,
   input  xlenWordT  retInsn_i,
   input  xlenWordT  retPc_i,
   input  xlenWordT  retPcNext_i,
   input  privModeT  retMode_i,

   input  logic      trapTrap_i,
   input  logic      trapException_i,
   input  excCauseT  trapCause_i,

   input  logic      intrIntr_i,
   input  logic      intrInterrupt_i,
   input  intrCauseT intrCause_i,
   input  logic      nmiPending_i,

   input  regAddrT   rdAddr_i,
   input  xlenWordT  rdWdata_i,
   input  logic      rdWe_i,

   output logic      traceValid_o,
   output orderT     traceOrder_o,
   output xlenWordT  traceInsn_o,
   output xlenWordT  tracePc_o,
   output xlenWordT  tracePcNext_o,
   output privModeT  traceMode_o,
   output logic      traceTrap_o,
   output logic      traceIntr_o,
   output logic [31:0] xWb_o,
   output xlenWordT  xWdata_o,

   output logic      retire_o,
   output logic      retTrapFault_o,
   output logic      retNmi_o,
   output intrCauseT retNmiCause_o
);

   logic        accept;
   logic        orderSeen;
   orderT       lastOrder;
   logic        validReg;
   logic [31:0] wbOneHot;
   logic [31:0] xWbReg;

   // A beat retires once; the core may hold the same order over several cycles
   assign accept = retValid_i && (!orderSeen || (retOrder_i != lastOrder));

   // x0 writes are not reported
   assign wbOneHot = (rdWe_i && (rdAddr_i != '0)) ? (32'b1 << rdAddr_i) : '0;

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         validReg  <= 1'b0;
         orderSeen <= 1'b0;
         lastOrder <= '0;
         xWbReg    <= '0;
      end else begin
         validReg <= accept;
         xWbReg   <= accept ? wbOneHot : '0;
         if (accept) begin
            lastOrder <= retOrder_i;
            orderSeen <= 1'b1;
         end
      end
   end

   ////////////////////////////////
   // Record and decoded flags
   ////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (accept) begin
         traceOrder_o   <= retOrder_i;
         traceInsn_o    <= retInsn_i;
         tracePc_o      <= retPc_i;
         tracePcNext_o  <= retPcNext_i;
         traceMode_o    <= retMode_i;
         // Only the fetch fault is a trap the checker cannot derive itself
         traceTrap_o    <= trapTrap_i && (trapCause_i == FetchFaultCause);
         traceIntr_o    <= intrIntr_i;
         xWdata_o       <= rdWdata_i;
         retTrapFault_o <= trapTrap_i && trapException_i && (trapCause_i == FetchFaultCause);
         retNmi_o       <= nmiPending_i || (intrIntr_i && intrInterrupt_i &&
                           ((intrCause_i == NmiLoadCause) || (intrCause_i == NmiStoreCause)));
         retNmiCause_o  <= intrCause_i;
      end
   end

   assign traceValid_o = validReg;
   assign retire_o     = validReg;
   assign xWb_o        = xWbReg;

endmodule

//--- design/csrShadow.sv
`timescale 1ns/1ns

module csrShadow
   import rvfiPkg::*;
#(
   parameter int NumCsr = 8
) (
   input  logic                    rvvi,
   input  logic                    reset_i,

   input  xlenWordT [NumCsr-1:0]   csrWdata_i,
   input  xlenWordT [NumCsr-1:0]   csrWmask_i,
   input  xlenWordT [NumCsr-1:0]   csrRdata_i,
   input  logic                    retire_i,

   output xlenWordT [NumCsr-1:0]   csrValue_o,
   output logic     [NumCsr-1:0]   csrWb_o
);

   xlenWordT [NumCsr-1:0] merged;
   xlenWordT [NumCsr-1:0] held;
   logic     [NumCsr-1:0] changed;
   logic     [NumCsr-1:0] wbFlag;

   ////////////////////////////////
   // Merge under write mask
   ////////////////////////////////
   always_comb begin
      for (int i = 0; i < NumCsr; i++) begin
         // Written bits from wdata, untouched bits from rdata
         merged[i]  = (csrWdata_i[i] & csrWmask_i[i]) | (csrRdata_i[i] & ~csrWmask_i[i]);
         changed[i] = (merged[i] != held[i]);
      end
   end

   // The held value also serves as the reference for change detection
   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         held   <= '0;
         wbFlag <= '0;
      end else begin
         held <= merged;
         for (int i = 0; i < NumCsr; i++) begin
            if (changed[i]) begin
               wbFlag[i] <= 1'b1;
            end else if (retire_i) begin
               // Flag covers exactly one retirement
               wbFlag[i] <= 1'b0;
            end
         end
      end
   end

   assign csrValue_o = held;
   assign csrWb_o    = wbFlag;

endmodule

//--- design/netEventDetect.sv
`timescale 1ns/1ns

module netEventDetect
   import rvfiPkg::*;
   import rvviPkg::*;
(
   input  logic      rvvi,
   input  logic      reset_i,

   input  logic [31:0] irq_i,
   input  logic      retire_i,
   input  logic      retTrapFault_i,
   input  logic      retNmi_i,
   input  intrCauseT retNmiCause_i,
   input  dbgCauseT  dbgCause_i,
   input  logic      dbgMode_i,

   input  logic      offerReady_i,
   output logic      offerValid_o,
   output netIdT     offerNet_o,
   output netValueT  offerValue_o
);

   netValueT             level     [NumNets];
   netValueT             levelNext [NumNets];
   netValueT             lastSent  [NumNets];
   logic [NumNets-1:0]   pending;
   logic                 haltCond;
   netIdT                offerIdx;
   logic                 offerTaken;

   // Debug entry caused by an external halt request
   assign haltCond = dbgMode_i && (dbgCause_i == DbgHaltCause);

   ////////////////////////////////
   // Next net levels
   ////////////////////////////////
   always_comb begin
      levelNext = level;

      // Interrupt lines follow the pins every cycle
      for (int i = 0; i < NumIrqNets; i++) begin
         levelNext[i] = netValueT'(irq_i[IrqLineTable[i]]);
      end

      // Fault and NMI only move with retirement
      if (retire_i) begin
         levelNext[NetIfault] = netValueT'(retTrapFault_i);
         levelNext[NetNmi]    = netValueT'(retNmi_i);
         if (retNmi_i) begin
            levelNext[NetNmiCause] = retNmiCause_i;
         end
      end

      // Halt request rises at once but only falls on a retirement
      if (haltCond) begin
         levelNext[NetHaltReq] = netValueT'(1);
      end else if (retire_i) begin
         levelNext[NetHaltReq] = '0;
      end
   end

   ////////////////////////////////
   // Pending and offer selection
   ////////////////////////////////
   always_comb begin
      for (int i = 0; i < NumNets; i++) begin
         pending[i] = (level[i] != lastSent[i]);
      end
   end

   // Lowest id wins; scanning down lets the last hit be the lowest
   always_comb begin
      offerIdx = '0;
      for (int i = NumNets - 1; i >= 0; i--) begin
         if (pending[i]) begin
            offerIdx = netIdT'(i);
         end
      end
   end

   assign offerValid_o = |pending;
   assign offerNet_o   = offerIdx;
   assign offerValue_o = level[offerIdx];
   assign offerTaken   = offerValid_o && offerReady_i;

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         for (int i = 0; i < NumNets; i++) begin
            level[i]    <= '0;
            lastSent[i] <= '0;
         end
      end else begin
         level <= levelNext;
         // A level that moved back to lastSent simply stops being pending
         if (offerTaken) begin
            lastSent[offerIdx] <= level[offerIdx];
         end
      end
   end

endmodule

//--- design/eventFifo.sv
`timescale 1ns/1ns

module eventFifo
   import rvviPkg::*;
#(
   parameter int FifoDepth = 4
) (
   input  logic     rvvi,
   input  logic     reset_i,

   input  logic     inValid_i,
   input  netIdT    inNet_i,
   input  netValueT inValue_i,
   output logic     inReady_o,

   output logic     outValid_o,
   output netIdT    outNet_o,
   output netValueT outValue_o,
   input  logic     outReady_i
);

   localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
   localparam int CntW = $clog2(FifoDepth + 1);

   localparam logic [PtrW-1:0] LastPtr  = PtrW'(FifoDepth - 1);
   localparam logic [CntW-1:0] FullCnt  = CntW'(FifoDepth);

   netIdT           netMem   [FifoDepth];
   netValueT        valueMem [FifoDepth];
   logic [PtrW-1:0] wrPtr;
   logic [PtrW-1:0] rdPtr;
   logic [CntW-1:0] count;
   logic            push;
   logic            pop;

   assign inReady_o  = (count != FullCnt);
   assign outValid_o = (count != '0);
   assign push       = inValid_i && inReady_o;
   assign pop        = outValid_o && outReady_i;

   // Head entry stays put until popped
   assign outNet_o   = netMem[rdPtr];
   assign outValue_o = valueMem[rdPtr];

   always_ff @(posedge rvvi) begin
      if (push) begin
         netMem[wrPtr]   <= inNet_i;
         valueMem[wrPtr] <= inValue_i;
      end
   end

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
         end
         count <= count + CntW'(push) - CntW'(pop);
      end
   end

endmodule

//--- design/traceTop.sv
`timescale 1ns/1ns

module traceTop
   import rvfiPkg::*;
   import rvviPkg::*;
#(
   parameter int NumCsr    = rvviPkg::NumCsr,
   parameter int FifoDepth = 4
) (
   input  logic                  rvvi,
   input  logic                  reset_i,

   input  logic                  retValid_i,
   input  orderT                 retOrder_i,
   input  xlenWordT              retInsn_i,
   input  xlenWordT              retPc_i,
   input  xlenWordT              retPcNext_i,
   input  privModeT              retMode_i,
   input  logic                  trapTrap_i,
   input  logic                  trapException_i,
   input  excCauseT              trapCause_i,
   input  logic                  intrIntr_i,
   input  logic                  intrInterrupt_i,
   input  intrCauseT             intrCause_i,
   input  logic                  nmiPending_i,
   input  dbgCauseT              dbgCause_i,
   input  logic                  dbgMode_i,
   input  regAddrT               rdAddr_i,
   input  xlenWordT              rdWdata_i,
   input  logic                  rdWe_i,
   input  xlenWordT [NumCsr-1:0] csrWdata_i,
   input  xlenWordT [NumCsr-1:0] csrWmask_i,
   input  xlenWordT [NumCsr-1:0] csrRdata_i,
   input  logic [31:0]           irq_i,
   input  logic                  eventReady_i,

   output logic                  traceValid_o,
   output orderT                 traceOrder_o,
   output xlenWordT              traceInsn_o,
   output xlenWordT              tracePc_o,
   output xlenWordT              tracePcNext_o,
   output privModeT              traceMode_o,
   output logic                  traceTrap_o,
   output logic                  traceIntr_o,
   output logic [31:0]           xWb_o,
   output xlenWordT              xWdata_o,
   output xlenWordT [NumCsr-1:0] csrValue_o,
   output logic [NumCsr-1:0]     csrWb_o,
   output logic                  eventValid_o,
   output netIdT                 eventNet_o,
   output netValueT              eventValue_o
);

   logic      retire;
   logic      retTrapFault;
   logic      retNmi;
   intrCauseT retNmiCause;
   logic      offerValid;
   logic      offerReady;
   netIdT     offerNet;
   netValueT  offerValue;

   //////////////////////////////
   // Retirement and GPR trace
   //////////////////////////////
   retireStage i_retireStage (
      .rvvi            (rvvi),
      .reset_i         (reset_i),
      .retValid_i      (retValid_i),
      .retOrder_i      (retOrder_i),
      .retInsn_i       (retInsn_i),
      .retPc_i         (retPc_i),
      .retPcNext_i     (retPcNext_i),
      .retMode_i       (retMode_i),
      .trapTrap_i      (trapTrap_i),
      .trapException_i (trapException_i),
      .trapCause_i     (trapCause_i),
      .intrIntr_i      (intrIntr_i),
      .intrInterrupt_i (intrInterrupt_i),
      .intrCause_i     (intrCause_i),
      .nmiPending_i    (nmiPending_i),
      .rdAddr_i        (rdAddr_i),
      .rdWdata_i       (rdWdata_i),
      .rdWe_i          (rdWe_i),
      .traceValid_o    (traceValid_o),
      .traceOrder_o    (traceOrder_o),
      .traceInsn_o     (traceInsn_o),
      .tracePc_o       (tracePc_o),
      .tracePcNext_o   (tracePcNext_o),
      .traceMode_o     (traceMode_o),
      .traceTrap_o     (traceTrap_o),
      .traceIntr_o     (traceIntr_o),
      .xWb_o           (xWb_o),
      .xWdata_o        (xWdata_o),
      .retire_o        (retire),
      .retTrapFault_o  (retTrapFault),
      .retNmi_o        (retNmi),
      .retNmiCause_o   (retNmiCause)
   );

   csrShadow #(
      .NumCsr (NumCsr)
   ) i_csrShadow (
      .rvvi       (rvvi),
      .reset_i    (reset_i),
      .csrWdata_i (csrWdata_i),
      .csrWmask_i (csrWmask_i),
      .csrRdata_i (csrRdata_i),
      .retire_i   (retire),
      .csrValue_o (csrValue_o),
      .csrWb_o    (csrWb_o)
   );

   //////////////////////////////
   // Net events
   //////////////////////////////
   netEventDetect i_netEventDetect (
      .rvvi           (rvvi),
      .reset_i        (reset_i),
      .irq_i          (irq_i),
      .retire_i       (retire),
      .retTrapFault_i (retTrapFault),
      .retNmi_i       (retNmi),
      .retNmiCause_i  (retNmiCause),
      .dbgCause_i     (dbgCause_i),
      .dbgMode_i      (dbgMode_i),
      .offerReady_i   (offerReady),
      .offerValid_o   (offerValid),
      .offerNet_o     (offerNet),
      .offerValue_o   (offerValue)
   );

   eventFifo #(
      .FifoDepth (FifoDepth)
   ) i_eventFifo (
      .rvvi       (rvvi),
      .reset_i    (reset_i),
      .inValid_i  (offerValid),
      .inNet_i    (offerNet),
      .inValue_i  (offerValue),
      .inReady_o  (offerReady),
      .outValid_o (eventValid_o),
      .outNet_o   (eventNet_o),
      .outValue_o (eventValue_o),
      .outReady_i (eventReady_i)
   );

endmodule

//--- bench/traceChecks.svh
`ifndef TRACE_CHECKS_SVH
`define TRACE_CHECKS_SVH

//////////////////////////////
// Reference model state
//////////////////////////////

// Retirement filter and registered record
logic          modelSeen;
orderT         modelLastOrder;
logic          modelRetire;
orderT         modelOrder;
xlenWordT      modelInsn;
xlenWordT      modelPc;
xlenWordT      modelPcNext;
privModeT      modelMode;
logic          modelTrap;
logic          modelIntr;
logic [31:0]   modelXWb;
xlenWordT      modelXWdata;
logic          modelFault;
logic          modelNmi;
intrCauseT     modelNmiCause;

// CSR shadow
xlenWordT      modelCsr [NumCsr];
logic [NumCsr-1:0] modelCsrWb;

// Net levels and the last value the checker received per net
netValueT      modelLevel [NumNets];
netValueT      modelRx    [NumNets];

// Detector last-sent values and the event FIFO contents, head first
netValueT      modelSent  [NumNets];
netIdT         modelQNet   [$];
netValueT      modelQValue [$];

task automatic resetModel();
   modelSeen      = 1'b0;
   modelLastOrder = '0;
   modelRetire    = 1'b0;
   modelXWb       = '0;
   modelFault     = 1'b0;
   modelNmi       = 1'b0;
   modelNmiCause  = '0;
   modelCsrWb     = '0;
   for (int i = 0; i < NumCsr; i++) begin
      modelCsr[i] = '0;
   end
   for (int i = 0; i < NumNets; i++) begin
      modelLevel[i] = '0;
      modelRx[i]    = '0;
      modelSent[i]  = '0;
   end
   modelQNet.delete();
   modelQValue.delete();
endtask

// One rising edge with the inputs that were applied before it
task automatic stepModel();
   logic     accept;
   logic     haltCond;
   logic     offerValid;
   logic     fifoFull;
   netIdT    offerNet;
   xlenWordT merged;
   accept   = retValid && (!modelSeen || (retOrder != modelLastOrder));
   haltCond = dbgMode && (dbgCause == DbgHaltCause);

   // The detector offers its lowest pending net; the FIFO takes it unless full
   offerValid = 1'b0;
   offerNet   = '0;
   for (int i = 0; i < NumNets; i++) begin
      if (!offerValid && (modelLevel[i] != modelSent[i])) begin
         offerValid = 1'b1;
         offerNet   = netIdT'(i);
      end
   end
   fifoFull = (modelQNet.size() == FifoDepth);
   if ((modelQNet.size() != 0) && eventReady) begin
      void'(modelQNet.pop_front());
      void'(modelQValue.pop_front());
   end
   if (offerValid && !fifoFull) begin
      modelQNet.push_back(offerNet);
      modelQValue.push_back(modelLevel[offerNet]);
      modelSent[offerNet] = modelLevel[offerNet];
   end

   // Levels see the retire pulse of the previous beat
   for (int i = 0; i < NumIrqNets; i++) begin
      modelLevel[i] = netValueT'(irq[IrqLineTable[i]]);
   end
   if (modelRetire) begin
      modelLevel[NetIfault] = netValueT'(modelFault);
      modelLevel[NetNmi]    = netValueT'(modelNmi);
      if (modelNmi) begin
         modelLevel[NetNmiCause] = modelNmiCause;
      end
   end
   if (haltCond) begin
      modelLevel[NetHaltReq] = netValueT'(1);
   end else if (modelRetire) begin
      modelLevel[NetHaltReq] = '0;
   end

   for (int i = 0; i < NumCsr; i++) begin
      merged = (csrWdata[i] & csrWmask[i]) | (csrRdata[i] & ~csrWmask[i]);
      if (merged != modelCsr[i]) begin
         modelCsrWb[i] = 1'b1;
      end else if (modelRetire) begin
         modelCsrWb[i] = 1'b0;
      end
      modelCsr[i] = merged;
   end

   modelRetire = accept;
   modelXWb    = '0;
   if (accept) begin
      modelSeen      = 1'b1;
      modelLastOrder = retOrder;
      modelOrder     = retOrder;
      modelInsn      = retInsn;
      modelPc        = retPc;
      modelPcNext    = retPcNext;
      modelMode      = retMode;
      modelTrap      = trapTrap && (trapCause == FetchFaultCause);
      modelIntr      = intrIntr;
      modelXWdata    = rdWdata;
      if (rdWe && (rdAddr != '0)) begin
         modelXWb = 32'h1 << rdAddr;
      end
      modelFault    = trapTrap && trapException && (trapCause == FetchFaultCause);
      modelNmi      = nmiPending || (intrIntr && intrInterrupt &&
                      ((intrCause == NmiLoadCause) || (intrCause == NmiStoreCause)));
      modelNmiCause = intrCause;
   end
endtask

//////////////////////////////
// Typed compare tasks
//////////////////////////////

task automatic checkOrder(input string name, input orderT expVal, input orderT actVal);
   if (actVal !== expVal) begin
      failRun($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                        $time, name, expVal, actVal));
   end
endtask

task automatic checkWord(input string name, input xlenWordT expVal, input xlenWordT actVal);
   if (actVal !== expVal) begin
      failRun($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                        $time, name, expVal, actVal));
   end
endtask

task automatic checkFlag(input string name, input logic expVal, input logic actVal);
   if (actVal !== expVal) begin
      failRun($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                        $time, name, expVal, actVal));
   end
endtask

task automatic checkEvent(input string name, input netIdT expNet, input netIdT actNet,
                          input netValueT expValue, input netValueT actValue);
   if ((actNet !== expNet) || (actValue !== expValue)) begin
      failRun($sformatf("CHECK FAILED at %0t: %s expected net %0d value %h got net %0d value %h",
                        $time, name, expNet, expValue, actNet, actValue));
   end
endtask

`endif

//--- bench/traceTb.sv
`timescale 1ns/1ns

module traceTb
   import rvfiPkg::*;
   import rvviPkg::*;
;

   localparam int StimCycles = 2000;
   localparam int CycleLimit = 20 * StimCycles;
   localparam int FifoDepth  = 4;

   logic                  rvvi;
   logic                  reset_i;
   logic                  retValid;
   orderT                 retOrder;
   xlenWordT              retInsn;
   xlenWordT              retPc;
   xlenWordT              retPcNext;
   privModeT              retMode;
   logic                  trapTrap;
   logic                  trapException;
   excCauseT              trapCause;
   logic                  intrIntr;
   logic                  intrInterrupt;
   intrCauseT             intrCause;
   logic                  nmiPending;
   dbgCauseT              dbgCause;
   logic                  dbgMode;
   regAddrT               rdAddr;
   xlenWordT              rdWdata;
   logic                  rdWe;
   xlenWordT [NumCsr-1:0] csrWdata;
   xlenWordT [NumCsr-1:0] csrWmask;
   xlenWordT [NumCsr-1:0] csrRdata;
   logic [31:0]           irq;
   logic                  eventReady;

   logic                  traceValid_o;
   orderT                 traceOrder_o;
   xlenWordT              traceInsn_o;
   xlenWordT              tracePc_o;
   xlenWordT              tracePcNext_o;
   privModeT              traceMode_o;
   logic                  traceTrap_o;
   logic                  traceIntr_o;
   logic [31:0]           xWb_o;
   xlenWordT              xWdata_o;
   xlenWordT [NumCsr-1:0] csrValue_o;
   logic [NumCsr-1:0]     csrWb_o;
   logic                  eventValid_o;
   netIdT                 eventNet_o;
   netValueT              eventValue_o;

   // Event stream as it stood before the last rising edge
   logic                  prevValid;
   logic                  prevReady;
   netIdT                 prevNet;
   netValueT              prevValue;
   orderT                 nextOrder;
   int                    cycleCount;

   traceTop #(
      .NumCsr    (NumCsr),
      .FifoDepth (FifoDepth)
   ) i_dut (
      .rvvi            (rvvi),
      .reset_i         (reset_i),
      .retValid_i      (retValid),
      .retOrder_i      (retOrder),
      .retInsn_i       (retInsn),
      .retPc_i         (retPc),
      .retPcNext_i     (retPcNext),
      .retMode_i       (retMode),
      .trapTrap_i      (trapTrap),
      .trapException_i (trapException),
      .trapCause_i     (trapCause),
      .intrIntr_i      (intrIntr),
      .intrInterrupt_i (intrInterrupt),
      .intrCause_i     (intrCause),
      .nmiPending_i    (nmiPending),
      .dbgCause_i      (dbgCause),
      .dbgMode_i       (dbgMode),
      .rdAddr_i        (rdAddr),
      .rdWdata_i       (rdWdata),
      .rdWe_i          (rdWe),
      .csrWdata_i      (csrWdata),
      .csrWmask_i      (csrWmask),
      .csrRdata_i      (csrRdata),
      .irq_i           (irq),
      .eventReady_i    (eventReady),
      .traceValid_o    (traceValid_o),
      .traceOrder_o    (traceOrder_o),
      .traceInsn_o     (traceInsn_o),
      .tracePc_o       (tracePc_o),
      .tracePcNext_o   (tracePcNext_o),
      .traceMode_o     (traceMode_o),
      .traceTrap_o     (traceTrap_o),
      .traceIntr_o     (traceIntr_o),
      .xWb_o           (xWb_o),
      .xWdata_o        (xWdata_o),
      .csrValue_o      (csrValue_o),
      .csrWb_o         (csrWb_o),
      .eventValid_o    (eventValid_o),
      .eventNet_o      (eventNet_o),
      .eventValue_o    (eventValue_o)
   );

   initial begin
      rvvi = 1'b0;
      forever #5 rvvi = ~rvvi;
   end

   task automatic failRun(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   `include "traceChecks.svh"

   always @(posedge rvvi) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= CycleLimit) begin
         failRun("Timeout: the run went past its cycle limit");
      end
   end

   ////////////////////////////////
   // Stimulus
   ////////////////////////////////
   task automatic driveRandom();
      // Most beats advance the order and some repeat it
      if ($urandom_range(0, 3) != 0) begin
         nextOrder = nextOrder + 64'd1;
      end
      retValid      = ($urandom_range(0, 3) != 0);
      retOrder      = nextOrder;
      retInsn       = $urandom();
      retPc         = $urandom();
      retPcNext     = $urandom();
      retMode       = privModeT'($urandom());
      trapTrap      = ($urandom_range(0, 2) == 0);
      trapException = ($urandom_range(0, 1) != 0);
      trapCause     = ($urandom_range(0, 1) != 0) ? FetchFaultCause : excCauseT'($urandom());
      intrIntr      = ($urandom_range(0, 2) == 0);
      intrInterrupt = ($urandom_range(0, 1) != 0);
      case ($urandom_range(0, 2))
         0: intrCause = NmiLoadCause;
         1: intrCause = NmiStoreCause;
         default: intrCause = intrCauseT'($urandom());
      endcase
      nmiPending = ($urandom_range(0, 7) == 0);
      if ($urandom_range(0, 3) == 0) begin
         dbgMode = ~dbgMode;
      end
      dbgCause = ($urandom_range(0, 1) != 0) ? DbgHaltCause : dbgCauseT'($urandom());
      rdAddr   = regAddrT'($urandom());
      rdWdata  = $urandom();
      rdWe     = ($urandom_range(0, 1) != 0);
      // CSR inputs stay put most cycles so changed flags get to clear
      for (int i = 0; i < NumCsr; i++) begin
         if ($urandom_range(0, 3) == 0) begin
            csrWdata[i] = $urandom();
            csrRdata[i] = $urandom();
            csrWmask[i] = ($urandom_range(0, 1) != 0) ? 32'hFFFF_FFFF : $urandom();
         end
      end
      if ($urandom_range(0, 2) == 0) begin
         irq = irq ^ (32'h1 << $urandom_range(0, 31));
      end
      eventReady = ($urandom_range(0, 2) != 0);
   endtask

   ////////////////////////////////
   // Output checks
   ////////////////////////////////
   task automatic checkOutputs();
      checkFlag("traceValid_o", modelRetire, traceValid_o);
      checkWord("xWb_o", modelXWb, xWb_o);
      if (modelRetire) begin
         checkOrder("traceOrder_o", modelOrder, traceOrder_o);
         checkWord("traceInsn_o", modelInsn, traceInsn_o);
         checkWord("tracePc_o", modelPc, tracePc_o);
         checkWord("tracePcNext_o", modelPcNext, tracePcNext_o);
         checkWord("traceMode_o", xlenWordT'(modelMode), xlenWordT'(traceMode_o));
         checkFlag("traceTrap_o", modelTrap, traceTrap_o);
         checkFlag("traceIntr_o", modelIntr, traceIntr_o);
         checkWord("xWdata_o", modelXWdata, xWdata_o);
      end
      for (int i = 0; i < NumCsr; i++) begin
         checkWord($sformatf("csrValue_o[%0d]", i), modelCsr[i], csrValue_o[i]);
         checkFlag($sformatf("csrWb_o[%0d]", i), modelCsrWb[i], csrWb_o[i]);
      end
      checkFlag("eventValid_o", (modelQNet.size() != 0), eventValid_o);
      if (modelQNet.size() != 0) begin
         checkEvent("event at FIFO head", modelQNet[0], eventNet_o,
                    modelQValue[0], eventValue_o);
      end
   endtask

   task automatic receiveEvent(input netIdT net, input netValueT value);
      if (int'(net) >= NumNets) begin
         failRun($sformatf("Event names net %0d, which does not exist", net));
      end
      if ((net != NetNmiCause) && (value > netValueT'(1))) begin
         failRun($sformatf("Event on one-bit net %0d carries value %h", net, value));
      end
      // A net never repeats the value it sent last
      if (value == modelRx[net]) begin
         failRun($sformatf("Net %0d sent value %h twice in a row", net, value));
      end
      modelRx[net] = value;
   endtask

   task automatic checkStream();
      if (prevValid && prevReady) begin
         receiveEvent(prevNet, prevValue);
      end else if (prevValid) begin
         checkFlag("eventValid_o under back-pressure", 1'b1, eventValid_o);
         checkEvent("event under back-pressure", prevNet, eventNet_o, prevValue, eventValue_o);
      end
   endtask

   task automatic recordStream();
      prevValid = eventValid_o;
      prevReady = eventReady;
      prevNet   = eventNet_o;
      prevValue = eventValue_o;
   endtask

   task automatic stepCycle();
      @(negedge rvvi);
      stepModel();
      checkOutputs();
      checkStream();
   endtask

   ////////////////////////////////
   // Main sequence
   ////////////////////////////////
   initial begin
      int quiet;
      reset_i       = 1'b1;
      retValid      = 1'b0;
      retOrder      = '0;
      retInsn       = '0;
      retPc         = '0;
      retPcNext     = '0;
      retMode       = '0;
      trapTrap      = 1'b0;
      trapException = 1'b0;
      trapCause     = '0;
      intrIntr      = 1'b0;
      intrInterrupt = 1'b0;
      intrCause     = '0;
      nmiPending    = 1'b0;
      dbgCause      = '0;
      dbgMode       = 1'b0;
      rdAddr        = '0;
      rdWdata       = '0;
      rdWe          = 1'b0;
      csrWdata      = '0;
      csrWmask      = '0;
      csrRdata      = '0;
      irq           = '0;
      eventReady    = 1'b0;
      nextOrder     = '0;
      cycleCount    = 0;
      void'($urandom(32'ha747));
      resetModel();

      repeat (10) @(negedge rvvi);
      reset_i = 1'b0;
      checkOutputs();
      driveRandom();
      recordStream();

      for (int cycle = 0; cycle < StimCycles; cycle++) begin
         stepCycle();
         driveRandom();
         recordStream();
      end

      // Drain with quiet inputs and the checker always ready
      retValid   = 1'b0;
      eventReady = 1'b1;
      recordStream();
      quiet = 0;
      while (quiet < 4) begin
         stepCycle();
         if (eventValid_o) begin
            quiet = 0;
         end else begin
            quiet = quiet + 1;
         end
         recordStream();
      end

      for (int i = 0; i < NumNets; i++) begin
         checkEvent("last value received after drain", netIdT'(i), netIdT'(i),
                    modelLevel[i], modelRx[i]);
      end

      $display("Everything OK");
      $finish;
   end

endmodule

//--- sim.f
+incdir+bench
design/rvfiPkg.sv
design/rvviPkg.sv
design/retireStage.sv
design/csrShadow.sv
design/netEventDetect.sv
design/eventFifo.sv
design/traceTop.sv
bench/traceTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
   && verilator --binary --timing --top-module traceTb -f sim.f -o traceSim \
   && ./obj_dir/traceSim \
   || { echo "Build or simulation did not pass"; exit 1; }
